//--- build.f
source/dcache_pkg.sv
source/dcache_tag_if.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_line_merge.sv
source/dcache_control.sv
source/dcache_top.sv
verification/dcache_assert.sv
verification/dcache_memory_model.sv
verification/dcache_tb.sv

//--- Makefile
SOURCES := $(wildcard source/*.sv verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vdcache_tb: build.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module dcache_tb -f build.f

run: obj_dir/Vdcache_tb
	obj_dir/Vdcache_tb +verilator+error+limit+100 | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

    localparam int timeout_cycles = 4000;      // 2 rounds of 11 requests, slow ready included

    logic clock = 1'b0;
    logic reset = 1'b1;
    logic valid;
    logic write;
    dcache_pkg::addr_t addr;
    dcache_pkg::strobe_t wstrb;
    dcache_pkg::word_t wdata;
    logic ready;
    logic data_ok;
    dcache_pkg::word_t rdata;
    logic rd_req;
    dcache_pkg::addr_t rd_addr;
    logic rd_rdy;
    logic ret_valid;
    logic ret_last;
    dcache_pkg::word_t ret_data;
    logic wr_req;
    dcache_pkg::addr_t wr_addr;
    dcache_pkg::line_t wr_data;
    logic wr_rdy;
    logic wr_resp;
    logic random_delays;

    int errors = 0;
    int assert_failures;
    int cycles = 0;
    int round_index;
    int latency;
    dcache_pkg::addr_t rd_log[$];
    dcache_pkg::addr_t wb_addr_log[$];
    dcache_pkg::line_t wb_data_log[$];
    int wb_rd_mark[$];                         // refills accepted before each writeback
    dcache_pkg::word_t first_round[$];
    dcache_pkg::word_t second_round[$];
    dcache_pkg::word_t expect_mem[dcache_pkg::addr_t];

    dcache_top dcache_top_inst (.*);
    dcache_memory_model memory_inst (.*);

    bind dcache_top dcache_assert assert_inst (
        .clock(clock), .reset(reset), .ready(ready), .data_ok(data_ok),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (!reset && rd_req && rd_rdy) begin
            rd_log.push_back(rd_addr);
        end
        if (!reset && wr_req && wr_rdy) begin
            wb_addr_log.push_back(wr_addr);
            wb_data_log.push_back(wr_data);
            wb_rd_mark.push_back(rd_log.size());
        end
        if (cycles == timeout_cycles) begin
            $display("timeout: the cache gave no answer within %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic dcache_pkg::word_t memory_word(dcache_pkg::addr_t a);
        return {a ^ 32'hc3a5_0f96, ~a + 32'h0101_0101};
    endfunction

    function automatic dcache_pkg::word_t expected_word(dcache_pkg::addr_t a);
        return expect_mem.exists(a) ? expect_mem[a] : memory_word(a);
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(dcache_pkg::word_t old_word,
            dcache_pkg::word_t new_word, dcache_pkg::strobe_t strobes);
        dcache_pkg::word_t merged;
        merged = old_word;
        for (int i = 0; i < 8; i++) begin
            if (strobes[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_word(input string name, input dcache_pkg::word_t expected,
                              input dcache_pkg::word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input dcache_pkg::addr_t expected,
                              input dcache_pkg::addr_t actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_line(input string name, input dcache_pkg::line_t expected,
                              input dcache_pkg::line_t actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // one request, returns the reply word and sets latency
    task automatic access(input logic is_write, input dcache_pkg::addr_t a,
                          input dcache_pkg::strobe_t s, input dcache_pkg::word_t d,
                          output dcache_pkg::word_t result);
        @(negedge clock);
        while (!ready) begin
            @(negedge clock);
        end
        valid = 1'b1;
        write = is_write;
        addr = a;
        wstrb = s;
        wdata = d;
        @(negedge clock);                      // taken at the edge before
        valid = 1'b0;
        latency = 1;
        while (!data_ok) begin
            @(negedge clock);
            latency++;
        end
        result = rdata;
        if (is_write) begin
            expect_mem[a] = merge_bytes(expected_word(a), d, s);
        end
    endtask

    task automatic read_check(input string name, input dcache_pkg::addr_t a);
        dcache_pkg::word_t r;
        access(1'b0, a, '0, '0, r);
        check_word(name, expected_word(a), r);
        if (round_index == 0) begin
            first_round.push_back(r);
        end else begin
            second_round.push_back(r);
        end
    endtask

    task automatic write_word(input dcache_pkg::addr_t a, input dcache_pkg::strobe_t s,
                              input dcache_pkg::word_t d);
        dcache_pkg::word_t ignored;
        access(1'b1, a, s, d, ignored);
    endtask

    task automatic read_miss_test();
        int reads;
        reads = rd_log.size();
        read_check("read_miss", 32'h0001_2348);
        check_count("read_miss requests", reads + 1, rd_log.size());
        check_addr("read_miss line", 32'h0001_2340, rd_log[rd_log.size() - 1]);
    endtask

    task automatic read_hit_test();
        int requests;
        requests = rd_log.size() + wb_addr_log.size();
        read_check("read_hit", 32'h0001_2348);
        check_count("read_hit latency", 2, latency);
        check_count("read_hit bus requests", requests, rd_log.size() + wb_addr_log.size());
    endtask

    task automatic write_hit_test();
        int reads;
        reads = rd_log.size();
        write_word(32'h0001_2340, 8'b1010_0101, 64'h1122_3344_5566_7788);
        check_count("write_hit latency", 2, latency);
        read_check("write_hit readback", 32'h0001_2340);
        check_count("write_hit bus requests", reads, rd_log.size());
    endtask

    task automatic write_miss_test();
        int reads;
        reads = rd_log.size();
        write_word(32'h0004_5678, 8'hc3, 64'h0a0b_0c0d_0e0f_1011);
        check_count("write_miss refills", reads + 1, rd_log.size());
        check_addr("write_miss line", 32'h0004_5670, rd_log[rd_log.size() - 1]);
        read_check("write_miss merged", 32'h0004_5678);
        read_check("write_miss other half", 32'h0004_5670);
    endtask

    // three tags in set 0x10, the third evicts way 0
    task automatic replacement_test();
        int reads;
        int writebacks;
        dcache_pkg::line_t evicted;
        write_word(32'h0010_0100, 8'hf0, 64'hdead_beef_0000_0000);
        write_word(32'h0020_0108, 8'h0f, 64'h0000_0000_1234_5678);
        evicted.words[0] = expected_word(32'h0010_0100);
        evicted.words[1] = expected_word(32'h0010_0108);
        reads = rd_log.size();
        writebacks = wb_addr_log.size();
        read_check("replace third tag", 32'h0030_0108);
        check_count("replace writebacks", writebacks + 1, wb_addr_log.size());
        check_addr("replace writeback address", 32'h0010_0100, wb_addr_log[writebacks]);
        check_line("replace writeback data", evicted, wb_data_log[writebacks]);
        check_count("replace writeback before refill", reads, wb_rd_mark[writebacks]);
        check_addr("replace refill address", 32'h0030_0100, rd_log[reads]);
        read_check("replace evicted tag", 32'h0010_0100);
        check_count("replace evicted refill", reads + 2, rd_log.size());
    endtask

    initial begin
        valid = 1'b0;
        write = 1'b0;
        addr = '0;
        wstrb = '0;
        wdata = '0;
        random_delays = 1'b0;
        for (round_index = 0; round_index < 2; round_index++) begin
            reset = 1'b1;
            expect_mem.delete();
            repeat (2) @(negedge clock);
            reset = 1'b0;
            random_delays = round_index == 1;  // second round with slow ready
            read_miss_test();
            read_hit_test();
            write_hit_test();
            write_miss_test();
            replacement_test();
        end
        foreach (first_round[i]) begin
            check_word("back_pressure repeat", first_round[i], second_round[i]);
        end
        assert_failures = dcache_top_inst.assert_inst.failures;
        $display("errors: %0d failed checks, %0d failed assertions", errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/dcache_memory_model.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_memory_model (
    input logic clock,
    input logic reset,
    input logic random_delays,
    input logic rd_req,
    input dcache_pkg::addr_t rd_addr,
    output logic rd_rdy,
    output logic ret_valid,
    output logic ret_last,
    output dcache_pkg::word_t ret_data,
    input logic wr_req,
    input dcache_pkg::addr_t wr_addr,
    input dcache_pkg::line_t wr_data,
    output logic wr_rdy,
    output logic wr_resp
);

    dcache_pkg::line_t lines [dcache_pkg::addr_t];    // only lines written back
    dcache_pkg::line_t beat_line;
    int seed = 85;
    int beats_left = 0;
    logic resp_due = 1'b0;
    logic in_reset = 1'b1;

    function automatic dcache_pkg::line_t line_at(dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        if (lines.exists(a)) begin
            l = lines[a];
        end else begin
            l.words[0] = {a ^ 32'hc3a5_0f96, ~a + 32'h0101_0101};
            l.words[1] = {(a + 32'd8) ^ 32'hc3a5_0f96, ~(a + 32'd8) + 32'h0101_0101};
        end
        return l;
    endfunction

    initial begin
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        wr_rdy = 1'b0;
        wr_resp = 1'b0;
    end

    always @(posedge clock) begin
        in_reset <= reset;                     // what the cache saw at this edge
    end

    always @(negedge clock) begin
        if (in_reset) begin
            lines.delete();
            beats_left = 0;
            resp_due = 1'b0;
        end
        ret_valid = 1'b0;
        ret_last = 1'b0;
        if (beats_left != 0) begin
            ret_valid = 1'b1;
            ret_last = beats_left == 1;
            ret_data = beat_line.words[beats_left == 1];  // low half first
            beats_left--;
        end
        wr_resp = resp_due;
        resp_due = 1'b0;
        rd_rdy = rd_req && (!random_delays || (($random(seed) & 3) == 0));
        wr_rdy = wr_req && (!random_delays || (($random(seed) & 3) == 0));
        if (rd_req && rd_rdy) begin
            beat_line = line_at(rd_addr);
            beats_left = 2;
        end
        if (wr_req && wr_rdy) begin
            lines[wr_addr] = wr_data;
            resp_due = 1'b1;
            $display("memory: writeback line %h data %h", wr_addr, wr_data);
        end
    end

endmodule

`default_nettype wire

//--- verification/dcache_assert.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_assert (
    input logic clock,
    input logic reset,
    input logic ready,
    input logic data_ok,
    input logic rd_req,
    input dcache_pkg::addr_t rd_addr,
    input logic rd_rdy,
    input logic wr_req,
    input dcache_pkg::addr_t wr_addr,
    input dcache_pkg::line_t wr_data,
    input logic wr_rdy
);

    int failures = 0;

    data_ok_single: assert property (@(posedge clock) disable iff (reset)
        data_ok |=> !data_ok)
    else begin
        failures++;
        $error("data_ok stayed high for more than one cycle");
    end

    // requests hold until the memory side takes them
    rd_request_hold: assert property (@(posedge clock) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
    else begin
        failures++;
        $error("read request dropped or changed before ready");
    end

    wr_request_hold: assert property (@(posedge clock) disable iff (reset)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
    else begin
        failures++;
        $error("write request dropped or changed before ready");
    end

    one_request: assert property (@(posedge clock) disable iff (reset)
        !(rd_req && wr_req))
    else begin
        failures++;
        $error("read and write requests raised together");
    end

    busy_not_ready: assert property (@(posedge clock) disable iff (reset)
        (rd_req || wr_req) |-> !ready)
    else begin
        failures++;
        $error("ready high while a bus request is pending");
    end

endmodule

`default_nettype wire

//--- source/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
    parameter int index_bits = 7
) (
    input logic clock,
    input logic reset,
    input logic valid,
    input logic write,
    input dcache_pkg::addr_t addr,
    input dcache_pkg::strobe_t wstrb,
    input dcache_pkg::word_t wdata,
    output logic ready,
    output logic data_ok,
    output dcache_pkg::word_t rdata,
    output logic rd_req,
    output dcache_pkg::addr_t rd_addr,
    input logic rd_rdy,
    input logic ret_valid,
    input logic ret_last,
    input dcache_pkg::word_t ret_data,
    output logic wr_req,
    output dcache_pkg::addr_t wr_addr,
    output dcache_pkg::line_t wr_data,
    input logic wr_rdy,
    input logic wr_resp
);

    logic data_read;
    logic data_write;
    logic data_way;
    logic [index_bits-1:0] data_index;
    dcache_pkg::line_mask_t data_mask;
    dcache_pkg::line_t data_line;
    dcache_pkg::line_t read_line;
    dcache_pkg::line_t merge_base;
    logic [dcache_pkg::offset_bits-1:0] merge_offset;
    dcache_pkg::strobe_t merge_wstrb;
    dcache_pkg::word_t merge_wdata;
    dcache_pkg::line_t merged_line;
    dcache_pkg::line_mask_t store_mask;

    dcache_tag_if #(.index_bits(index_bits)) tag_bus ();

    dcache_control #(.index_bits(index_bits)) control_inst (
        .clock(clock), .reset(reset),
        .valid(valid), .write(write), .addr(addr), .wstrb(wstrb), .wdata(wdata),
        .ready(ready), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .wr_rdy(wr_rdy), .wr_resp(wr_resp),
        .tags(tag_bus.control),
        .data_read(data_read), .data_write(data_write), .data_way(data_way),
        .data_index(data_index), .data_mask(data_mask), .data_line(data_line),
        .read_line(read_line),
        .merge_base(merge_base), .merge_offset(merge_offset),
        .merge_wstrb(merge_wstrb), .merge_wdata(merge_wdata),
        .merged_line(merged_line), .store_mask(store_mask)
    );

    dcache_tag_store #(.index_bits(index_bits)) tag_store_inst (
        .clock(clock), .reset(reset), .tags(tag_bus.store)
    );

    dcache_data_store #(.index_bits(index_bits)) data_store_inst (
        .clock(clock), .read(data_read), .write(data_write), .way(data_way),
        .index(data_index), .mask(data_mask), .line(data_line), .read_line(read_line)
    );

    dcache_line_merge line_merge_inst (
        .base(merge_base), .offset(merge_offset), .wstrb(merge_wstrb), .wdata(merge_wdata),
        .merged(merged_line), .mask(store_mask)
    );

endmodule

`default_nettype wire

//--- source/dcache_control.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_control #(
    parameter int index_bits = 7
) (
    input logic clock,
    input logic reset,
    input logic valid,
    input logic write,
    input dcache_pkg::addr_t addr,
    input dcache_pkg::strobe_t wstrb,
    input dcache_pkg::word_t wdata,
    output logic ready,
    output logic data_ok,
    output dcache_pkg::word_t rdata,
    output logic rd_req,
    output dcache_pkg::addr_t rd_addr,
    input logic rd_rdy,
    input logic ret_valid,
    input logic ret_last,
    input dcache_pkg::word_t ret_data,
    output logic wr_req,
    output dcache_pkg::addr_t wr_addr,
    output dcache_pkg::line_t wr_data,
    input logic wr_rdy,
    input logic wr_resp,
    dcache_tag_if.control tags,
    output logic data_read,
    output logic data_write,
    output logic data_way,
    output logic [index_bits-1:0] data_index,
    output dcache_pkg::line_mask_t data_mask,
    output dcache_pkg::line_t data_line,
    input dcache_pkg::line_t read_line,
    output dcache_pkg::line_t merge_base,
    output logic [dcache_pkg::offset_bits-1:0] merge_offset,
    output dcache_pkg::strobe_t merge_wstrb,
    output dcache_pkg::word_t merge_wdata,
    input dcache_pkg::line_t merged_line,
    input dcache_pkg::line_mask_t store_mask
);

    localparam int tag_bits = dcache_pkg::addr_bits - dcache_pkg::offset_bits - index_bits;

    localparam logic [3:0] st_idle = 4'd0;
    localparam logic [3:0] st_lookup = 4'd1;
    localparam logic [3:0] st_hit_read = 4'd2;
    localparam logic [3:0] st_victim_read = 4'd3;
    localparam logic [3:0] st_wb_req = 4'd4;
    localparam logic [3:0] st_wb_resp = 4'd5;
    localparam logic [3:0] st_refill_req = 4'd6;
    localparam logic [3:0] st_refill_beats = 4'd7;
    localparam logic [3:0] st_fill = 4'd8;

    logic [3:0] state;
    logic from_fill;                           // reply word comes from the refill line
    logic req_write;
    dcache_pkg::addr_t req_addr;
    dcache_pkg::strobe_t req_wstrb;
    dcache_pkg::word_t req_wdata;
    dcache_pkg::line_t fill_line;
    dcache_pkg::line_t reply_line;

    logic [index_bits-1:0] req_index;
    logic [tag_bits-1:0] req_tag;
    logic lookup_hit;
    logic filling;

    assign req_index = req_addr[dcache_pkg::offset_bits +: index_bits];
    assign req_tag = req_addr[dcache_pkg::addr_bits-1 -: tag_bits];
    assign lookup_hit = (state == st_lookup) && tags.hit;
    assign filling = state == st_fill;

    assign ready = state == st_idle;
    assign data_ok = state == st_hit_read;     // reply cycle, also closes misses
    assign reply_line = from_fill ? fill_line : read_line;
    assign rdata = reply_line.words[req_addr[3]];

    assign rd_req = state == st_refill_req;
    assign rd_addr = {req_addr[dcache_pkg::addr_bits-1:dcache_pkg::offset_bits],
                      {dcache_pkg::offset_bits{1'b0}}};
    assign wr_req = state == st_wb_req;
    assign wr_addr = {tags.victim_tag, req_index, {dcache_pkg::offset_bits{1'b0}}};
    assign wr_data = read_line;                // victim line held since victim read

    assign tags.index = req_index;
    assign tags.tag = req_tag;
    assign tags.update = filling;
    assign tags.set_dirty = lookup_hit && req_write;
    assign tags.update_way = filling ? tags.victim_way : tags.hit_way;
    assign tags.dirty_value = req_write;

    assign data_read = (lookup_hit && !req_write) || (state == st_victim_read);
    assign data_write = (lookup_hit && req_write) || filling;
    assign data_way = (state == st_lookup) ? tags.hit_way : tags.victim_way;
    assign data_index = req_index;
    assign data_mask = filling ? '1 : store_mask;
    assign data_line = (filling && !req_write) ? fill_line : merged_line;

    assign merge_base = fill_line;
    assign merge_offset = req_addr[dcache_pkg::offset_bits-1:0];
    assign merge_wstrb = req_wstrb;
    assign merge_wdata = req_wdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            from_fill <= 1'b0;
        end else begin
            case (state)
                st_idle: if (valid) state <= st_lookup;
                st_lookup: begin
                    from_fill <= !tags.hit;
                    if (tags.hit) begin
                        state <= st_hit_read;
                    end else if (tags.victim_dirty) begin
                        state <= st_victim_read;
                    end else begin
                        state <= st_refill_req;
                    end
                end
                st_hit_read: state <= st_idle;
                st_victim_read: state <= st_wb_req;
                st_wb_req: if (wr_rdy) state <= st_wb_resp;
                st_wb_resp: if (wr_resp) state <= st_refill_req;
                st_refill_req: if (rd_rdy) state <= st_refill_beats;
                st_refill_beats: if (ret_valid && ret_last) state <= st_fill;
                st_fill: state <= st_hit_read;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if ((state == st_idle) && valid) begin
            req_write <= write;
            req_addr <= addr;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
        if ((state == st_refill_beats) && ret_valid) begin
            fill_line.words[ret_last] <= ret_data;   // low half arrives first
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_line_merge.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_line_merge (
    input dcache_pkg::line_t base,
    input logic [dcache_pkg::offset_bits-1:0] offset,
    input dcache_pkg::strobe_t wstrb,
    input dcache_pkg::word_t wdata,
    output dcache_pkg::line_t merged,
    output dcache_pkg::line_mask_t mask
);

    dcache_pkg::strobe_t strb_shift;
    dcache_pkg::word_t data_shift;
    dcache_pkg::line_t store_line;

    // strobes and data move to the addressed byte lane
    assign strb_shift = wstrb << offset[2:0];
    assign data_shift = wdata << {offset[2:0], 3'b000};

    assign mask = offset[3] ? {strb_shift, 8'h00} : {8'h00, strb_shift};

    always_comb begin
        store_line = '0;
        store_line.words[offset[3]] = data_shift;
    end

    always_comb begin
        merged = base;
        for (int b = 0; b < dcache_pkg::line_bytes; b++) begin
            if (mask[b]) begin
                merged.bytes[b] = store_line.bytes[b];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_data_store.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_data_store #(
    parameter int index_bits = 7
) (
    input logic clock,
    input logic read,
    input logic write,
    input logic way,
    input logic [index_bits-1:0] index,
    input dcache_pkg::line_mask_t mask,
    input dcache_pkg::line_t line,
    output dcache_pkg::line_t read_line
);

    localparam int sets = 2 ** index_bits;

    dcache_pkg::line_t mem [2][sets];

    // byte lanes written only where mask is set
    always_ff @(posedge clock) begin
        if (write) begin
            for (int b = 0; b < dcache_pkg::line_bytes; b++) begin
                if (mask[b]) begin
                    mem[way][index].bytes[b] <= line.bytes[b];
                end
            end
        end
    end

    // output holds until the next read
    always_ff @(posedge clock) begin
        if (read) begin
            read_line <= mem[way][index];
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_store #(
    parameter int index_bits = 7
) (
    input logic clock,
    input logic reset,
    dcache_tag_if.store tags
);

    localparam int tag_bits = dcache_pkg::addr_bits - dcache_pkg::offset_bits - index_bits;
    localparam int sets = 2 ** index_bits;

    logic [tag_bits-1:0] tag_mem [2][sets];
    logic [1:0][sets-1:0] valid;
    logic [1:0][sets-1:0] dirty;

    logic valid0;
    logic valid1;
    logic dirty0;
    logic dirty1;
    logic hit0;
    logic hit1;

    assign valid0 = valid[0][tags.index];
    assign valid1 = valid[1][tags.index];
    assign dirty0 = dirty[0][tags.index];
    assign dirty1 = dirty[1][tags.index];

    assign hit0 = valid0 && (tag_mem[0][tags.index] == tags.tag);
    assign hit1 = valid1 && (tag_mem[1][tags.index] == tags.tag);

    assign tags.hit = hit0 || hit1;
    assign tags.hit_way = hit1;                // only meaningful with hit

    // invalid way first, then clean way, else way 0
    always_comb begin
        if (!valid0) begin
            tags.victim_way = 1'b0;
        end else if (!valid1) begin
            tags.victim_way = 1'b1;
        end else if (!dirty0) begin
            tags.victim_way = 1'b0;
        end else if (!dirty1) begin
            tags.victim_way = 1'b1;
        end else begin
            tags.victim_way = 1'b0;
        end
    end

    assign tags.victim_dirty = valid[tags.victim_way][tags.index]
                            && dirty[tags.victim_way][tags.index];
    assign tags.victim_tag = tag_mem[tags.victim_way][tags.index];

    always_ff @(posedge clock) begin
        if (tags.update) begin
            tag_mem[tags.update_way][tags.index] <= tags.tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (tags.update) begin
                valid[tags.update_way][tags.index] <= 1'b1;
            end
            if (tags.update || tags.set_dirty) begin
                dirty[tags.update_way][tags.index] <= tags.dirty_value;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_tag_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dcache_tag_if #(
    parameter int index_bits = 7
);

    localparam int tag_bits = dcache_pkg::addr_bits - dcache_pkg::offset_bits - index_bits;

    logic [index_bits-1:0] index;
    logic [tag_bits-1:0] tag;
    logic update;                              // write tag, set valid
    logic update_way;
    logic set_dirty;
    logic dirty_value;

    logic hit;
    logic hit_way;
    logic victim_way;
    logic victim_dirty;
    logic [tag_bits-1:0] victim_tag;

    modport control (
        output index, tag, update, update_way, set_dirty, dirty_value,
        input hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport store (
        input index, tag, update, update_way, set_dirty, dirty_value,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

endinterface

`default_nettype wire

//--- source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int addr_bits = 32;
    localparam int offset_bits = 4;            // 16 byte lines
    localparam int line_bytes = 16;

    typedef logic [63:0] word_t;
    typedef logic [7:0] strobe_t;              // one bit per byte of a word
    typedef logic [addr_bits-1:0] addr_t;

    // one line seen as bus beats or as bytes
    typedef union packed {
        word_t [1:0] words;                    // words[0] is the low half
        logic [line_bytes-1:0][7:0] bytes;
    } line_t;

    typedef logic [line_bytes-1:0] line_mask_t;

endpackage

`default_nettype wire
